// ==== stackCfgPkg.sv ====
`default_nettype none

package stackCfgPkg;

    // Stack word and cache line geometry
    localparam int dataWidth = 16;
    localparam int lineWords = 8;
    localparam int lineWidth = dataWidth * lineWords;

    // Direct-mapped window of four lines
    localparam int lineCount = 4;
    localparam int lineIndexBits = 2;
    localparam int wordOffsetBits = 3;

    // Addresses and the stack pointer are word addresses
    localparam int addrWidth = 32;
    localparam int lineNumBits = addrWidth - wordOffsetBits;
    localparam int tagBits = lineNumBits - lineIndexBits;

    // Line number drops the word offset
    function automatic logic [lineNumBits-1:0] lineNumOf(input logic [addrWidth-1:0] addr);
        return addr[addrWidth-1:wordOffsetBits];
    endfunction

    // Slot in the direct-mapped window
    function automatic logic [lineIndexBits-1:0] lineIndexOf(input logic [addrWidth-1:0] addr);
        return addr[wordOffsetBits +: lineIndexBits];
    endfunction

    function automatic logic [tagBits-1:0] tagOf(input logic [addrWidth-1:0] addr);
        return addr[addrWidth-1 -: tagBits];
    endfunction

    function automatic logic [wordOffsetBits-1:0] wordOffsetOf(input logic [addrWidth-1:0] addr);
        return addr[wordOffsetBits-1:0];
    endfunction

endpackage

`default_nettype wire

// ==== stackOpPkg.sv ====
`default_nettype none

package stackOpPkg;

    localparam int opBits = 3;

    // Operations the stack cache executes
    typedef enum logic [opBits-1:0] {
        opPush  = 3'd0,
        opPop   = 3'd1,
        opPick  = 3'd2,
        opPlace = 3'd3,
        opSetSp = 3'd4
    } stackOpT;

    // Status that travels with every result
    typedef enum logic {
        faultNone   = 1'b0,
        faultBounds = 1'b1
    } resultFaultT;

endpackage

`default_nettype wire

// ==== stackOpDecode.sv ====
`default_nettype none

module stackOpDecode
    import stackCfgPkg::*, stackOpPkg::*;
(
    input  wire                  clk,
    input  wire                  rstN,
    input  wire                  opValid,
    input  wire stackOpT         opCode,
    input  wire [dataWidth-1:0]  opData,
    input  wire [addrWidth-1:0]  opOffset,
    output logic                 opReady,
    input  wire [addrWidth-1:0]  stackPointer,
    input  wire [addrWidth-1:0]  stackUpperBound,
    input  wire [addrWidth-1:0]  stackLowerBound,
    input  wire                  stackDirection,
    input  wire                  decTake,
    output logic                 decValid,
    output stackOpT              decCode,
    output logic [addrWidth-1:0] decAddr,
    output logic [dataWidth-1:0] decData,
    output logic [addrWidth-1:0] decNewSp,
    output resultFaultT          decFault
);

    logic [addrWidth-1:0] towardSp;
    logic [addrWidth-1:0] awayOneSp;
    logic [addrWidth-1:0] awayOffSp;
    logic [addrWidth-1:0] nextAddr;
    logic [addrWidth-1:0] nextSp;
    resultFaultT          nextFault;

    // Register is free when empty or emptied this cycle
    assign opReady = !decValid || decTake;

    always_comb begin
        // Direction 0 grows down with a push
        towardSp  = stackDirection ? stackPointer + 32'd1 : stackPointer - 32'd1;
        awayOneSp = stackDirection ? stackPointer - 32'd1 : stackPointer + 32'd1;
        awayOffSp = stackDirection ? stackPointer - opOffset : stackPointer + opOffset;
        case (opCode)
            opPush: begin
                nextAddr = towardSp;
                nextSp   = towardSp;
            end
            opPop: begin
                nextAddr = stackPointer;
                nextSp   = awayOneSp;
            end
            opPick, opPlace: begin
                nextAddr = awayOffSp;
                nextSp   = stackPointer;
            end
            default: begin
                // SetSp loads the offset as the new pointer
                nextAddr = opOffset;
                nextSp   = opOffset;
            end
        endcase
        // Inclusive window, SetSp is exempt
        if ((opCode != opSetSp) &&
            ((nextAddr < stackLowerBound) || (nextAddr > stackUpperBound))) begin
            nextFault = faultBounds;
        end else begin
            nextFault = faultNone;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            decValid <= 1'b0;
        end else if (opReady) begin
            decValid <= opValid;
        end
    end

    // Payload only moves on a transfer
    always_ff @(posedge clk) begin
        if (opValid && opReady) begin
            decCode  <= opCode;
            decAddr  <= nextAddr;
            decData  <= opData;
            decNewSp <= nextSp;
            decFault <= nextFault;
        end
    end

endmodule

`default_nettype wire

// ==== stackLineStore.sv ====
`default_nettype none

module stackLineStore
    import stackCfgPkg::*;
(
    input  wire                    clk,
    input  wire                    rstN,
    input  wire  [addrWidth-1:0]   lookupAddr,
    output logic                   lookupHit,
    output logic [dataWidth-1:0]   rdData,
    input  wire                    wrEn,
    input  wire  [addrWidth-1:0]   wrAddr,
    input  wire  [dataWidth-1:0]   wrData,
    input  wire                    missReq,
    input  wire                    flushReq,
    output logic                   missDone,
    output logic                   flushDone,
    output logic                   fillReq,
    output logic [lineNumBits-1:0] fillLine,
    input  wire                    fillAck,
    input  wire  [lineWidth-1:0]   fillData,
    output logic                   evictReq,
    output logic [lineNumBits-1:0] evictLine,
    output logic [lineWidth-1:0]   evictData,
    input  wire                    evictAck
);

    typedef enum logic [1:0] {
        stIdle,
        stEvict,
        stFill,
        stFlush
    } storeStateT;

    logic [lineWidth-1:0]     lineData [lineCount];
    logic [tagBits-1:0]       lineTag  [lineCount];
    logic [lineCount-1:0]     lineValid;
    logic [lineCount-1:0]     lineDirty;
    storeStateT               state;
    logic [lineIndexBits-1:0] slot;
    logic                     flushMode;
    logic [lineIndexBits-1:0] lookIndex;
    logic [lineIndexBits-1:0] wrIndex;
    logic                     slotDirty;
    logic                     lastSlot;

    assign lookIndex = lineIndexOf(lookupAddr);
    assign wrIndex   = lineIndexOf(wrAddr);

    // Hit check and word read are combinational
    assign lookupHit = lineValid[lookIndex] && (lineTag[lookIndex] == tagOf(lookupAddr));
    assign rdData    = lineData[lookIndex][wordOffsetOf(lookupAddr)*dataWidth +: dataWidth];

    assign slotDirty = lineValid[slot] && lineDirty[slot];
    assign lastSlot  = (slot == lineIndexBits'(lineCount - 1));

    // Requests decode straight from state so they hold until the ack
    assign fillReq   = (state == stFill);
    assign fillLine  = lineNumOf(lookupAddr);
    assign evictReq  = (state == stEvict);
    assign evictLine = {lineTag[slot], slot};
    assign evictData = lineData[slot];

    assign missDone  = (state == stFill) && fillAck;
    assign flushDone = (state == stFlush) && !slotDirty && lastSlot;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state     <= stIdle;
            slot      <= '0;
            flushMode <= 1'b0;
            lineValid <= '0;
            lineDirty <= '0;
        end else begin
            // Word writes only land on present lines
            if (wrEn) begin
                lineDirty[wrIndex] <= 1'b1;
            end
            case (state)
                stIdle: begin
                    if (flushReq) begin
                        slot      <= '0;
                        flushMode <= 1'b1;
                        state     <= stFlush;
                    end else if (missReq) begin
                        // Dirty victim goes out before the fill
                        slot      <= lookIndex;
                        flushMode <= 1'b0;
                        if (lineValid[lookIndex] && lineDirty[lookIndex]) begin
                            state <= stEvict;
                        end else begin
                            state <= stFill;
                        end
                    end
                end
                stEvict: begin
                    if (evictAck) begin
                        lineDirty[slot] <= 1'b0;
                        state <= flushMode ? stFlush : stFill;
                    end
                end
                stFill: begin
                    if (fillAck) begin
                        lineValid[slot] <= 1'b1;
                        lineDirty[slot] <= 1'b0;
                        state <= stIdle;
                    end
                end
                default: begin
                    // Flush walk, revisits a slot after its evict
                    if (slotDirty) begin
                        state <= stEvict;
                    end else begin
                        lineValid[slot] <= 1'b0;
                        slot <= slot + 1'b1;
                        if (lastSlot) begin
                            state <= stIdle;
                        end
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (missDone) begin
            lineData[slot] <= fillData;
            lineTag[slot]  <= tagOf(lookupAddr);
        end else if (wrEn) begin
            lineData[wrIndex][wordOffsetOf(wrAddr)*dataWidth +: dataWidth] <= wrData;
        end
    end

    // One backing-memory exchange at a time
    assert property (@(posedge clk) disable iff (!rstN) !(fillReq && evictReq));

    // Line number and data hold until the ack
    assert property (@(posedge clk) disable iff (!rstN)
        fillReq && !fillAck |=> fillReq && $stable(fillLine));
    assert property (@(posedge clk) disable iff (!rstN)
        evictReq && !evictAck |=> evictReq && $stable(evictLine) && $stable(evictData));

endmodule

`default_nettype wire

// ==== stackExecute.sv ====
`default_nettype none

module stackExecute
    import stackCfgPkg::*, stackOpPkg::*;
(
    input  wire                  clk,
    input  wire                  rstN,
    input  wire                  decValid,
    input  wire stackOpT         decCode,
    input  wire [addrWidth-1:0]  decAddr,
    input  wire [dataWidth-1:0]  decData,
    input  wire [addrWidth-1:0]  decNewSp,
    input  wire resultFaultT     decFault,
    output logic                 decTake,
    input  wire                  stackDirection,
    input  wire [addrWidth-1:0]  stackUpperBound,
    input  wire [addrWidth-1:0]  stackLowerBound,
    output logic [addrWidth-1:0] stackPointer,
    output logic [addrWidth-1:0] lookupAddr,
    input  wire                  lookupHit,
    input  wire [dataWidth-1:0]  rdData,
    output logic                 wrEn,
    output logic [addrWidth-1:0] wrAddr,
    output logic [dataWidth-1:0] wrData,
    output logic                 missReq,
    output logic                 flushReq,
    input  wire                  missDone,
    input  wire                  flushDone,
    output logic                 execValid,
    output logic [dataWidth-1:0] execData,
    output resultFaultT          execFault,
    input  wire                  execTake
);

    typedef enum logic [1:0] {
        stIdle,
        stMiss,
        stFlush,
        stHandoff
    } execStateT;

    execStateT            state;
    execStateT            stateNext;
    logic [addrWidth-1:0] spReg;
    logic                 spLoaded;
    logic [addrWidth-1:0] spReset;
    logic                 isWrite;

    assign isWrite    = (decCode == opPush) || (decCode == opPlace);
    assign lookupAddr = decAddr;
    assign wrAddr     = decAddr;
    assign wrData     = decData;
    assign missReq    = (state == stMiss);
    assign flushReq   = (state == stFlush);

    // Pointer starts just outside the window on the empty side
    assign spReset = stackDirection ? stackLowerBound - 32'd1 : stackUpperBound + 32'd1;

    always_comb begin
        stateNext = state;
        execValid = 1'b0;
        execData  = '0;
        execFault = faultNone;
        wrEn      = 1'b0;
        decTake   = 1'b0;
        case (state)
            stIdle: begin
                if (decValid && (decFault == faultBounds)) begin
                    // Faulted op retires without touching the store
                    execValid = 1'b1;
                    execFault = faultBounds;
                    decTake   = execTake;
                end else if (decValid && (decCode == opSetSp)) begin
                    stateNext = stFlush;
                end else if (decValid && !lookupHit) begin
                    stateNext = stMiss;
                end else if (decValid) begin
                    // Hit commits the access together with the hand-off
                    execValid = 1'b1;
                    execData  = isWrite ? '0 : rdData;
                    wrEn      = isWrite && execTake;
                    decTake   = execTake;
                end
            end
            stMiss: begin
                // Back to idle to redo the hit check
                if (missDone) begin
                    stateNext = stIdle;
                end
            end
            stFlush: begin
                if (flushDone) begin
                    stateNext = stHandoff;
                end
            end
            default: begin
                // SetSp result after the flush
                execValid = 1'b1;
                decTake   = execTake;
                if (execTake) begin
                    stateNext = stIdle;
                end
            end
        endcase
    end

    // Decode sees the pointer of an op retiring this cycle
    always_comb begin
        if (!spLoaded) begin
            stackPointer = spReset;
        end else if (decTake && (decFault == faultNone)) begin
            stackPointer = decNewSp;
        end else begin
            stackPointer = spReg;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state    <= stIdle;
            spReg    <= '0;
            spLoaded <= 1'b0;
        end else begin
            state    <= stateNext;
            spReg    <= stackPointer;
            spLoaded <= 1'b1;
        end
    end

    // Decoded op stays put through a pending miss or flush
    assert property (@(posedge clk) disable iff (!rstN)
        (missReq || flushReq) |=>
            decValid && $stable(decAddr) && $stable(decCode) && $stable(decData));

endmodule

`default_nettype wire

// ==== stackResult.sv ====
`default_nettype none

module stackResult
    import stackCfgPkg::*, stackOpPkg::*;
(
    input  wire                  clk,
    input  wire                  rstN,
    input  wire                  execValid,
    input  wire [dataWidth-1:0]  execData,
    input  wire resultFaultT     execFault,
    output logic                 execTake,
    output logic                 resultValid,
    output logic [dataWidth-1:0] resultData,
    output resultFaultT          resultFault,
    input  wire                  resultReady
);

    // Accept when empty or drained this cycle
    assign execTake = !resultValid || resultReady;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            resultValid <= 1'b0;
        end else if (execTake) begin
            resultValid <= execValid;
        end
    end

    always_ff @(posedge clk) begin
        if (execTake && execValid) begin
            resultData  <= execData;
            resultFault <= execFault;
        end
    end

    // Held result stays put until the consumer takes it
    assert property (@(posedge clk) disable iff (!rstN)
        resultValid && !resultReady |=>
            resultValid && $stable(resultData) && $stable(resultFault));

endmodule

`default_nettype wire

// ==== stackCache.sv ====
`default_nettype none

module stackCache
    import stackCfgPkg::*, stackOpPkg::*;
(
    input  wire                    clk,
    input  wire                    rstN,
    input  wire                    opValid,
    input  wire stackOpT           opCode,
    input  wire  [dataWidth-1:0]   opData,
    input  wire  [addrWidth-1:0]   opOffset,
    output logic                   opReady,
    input  wire  [addrWidth-1:0]   stackUpperBound,
    input  wire  [addrWidth-1:0]   stackLowerBound,
    input  wire                    stackDirection,
    output logic                   resultValid,
    output logic [dataWidth-1:0]   resultData,
    output resultFaultT            resultFault,
    input  wire                    resultReady,
    output logic                   fillReq,
    output logic [lineNumBits-1:0] fillLine,
    input  wire                    fillAck,
    input  wire  [lineWidth-1:0]   fillData,
    output logic                   evictReq,
    output logic [lineNumBits-1:0] evictLine,
    output logic [lineWidth-1:0]   evictData,
    input  wire                    evictAck,
    output logic [addrWidth-1:0]   stackPointer
);

    // Decode to execute
    logic                 decValid;
    stackOpT              decCode;
    logic [addrWidth-1:0] decAddr;
    logic [dataWidth-1:0] decData;
    logic [addrWidth-1:0] decNewSp;
    resultFaultT          decFault;
    logic                 decTake;

    // Execute to line store
    logic [addrWidth-1:0] lookupAddr;
    logic                 lookupHit;
    logic [dataWidth-1:0] rdData;
    logic                 wrEn;
    logic [addrWidth-1:0] wrAddr;
    logic [dataWidth-1:0] wrData;
    logic                 missReq;
    logic                 flushReq;
    logic                 missDone;
    logic                 flushDone;

    // Execute to result
    logic                 execValid;
    logic [dataWidth-1:0] execData;
    resultFaultT          execFault;
    logic                 execTake;

    stackOpDecode u_opDecode (.*);

    stackExecute u_execute (.*);

    stackLineStore u_lineStore (.*);

    stackResult u_result (.*);

endmodule

`default_nettype wire

// ==== tbStackCache.sv ====
`default_nettype none

module tbStackCache
    import stackCfgPkg::*, stackOpPkg::*;
();

    // Bounds window, also the extent of the backing memory
    localparam logic [addrWidth-1:0] lowerBound = 32'h100;
    localparam logic [addrWidth-1:0] upperBound = 32'h17F;
    localparam int windowWords = 128;
    localparam int opsPerPhase = 300;
    // Random ops plus five directed ones, two phases
    localparam int opCount = 2 * (opsPerPhase + 5);
    localparam int cycleLimit = 40 * opCount + 2000;

    logic                   clk;
    logic                   rstN;
    logic                   opValid;
    stackOpT                opCode;
    logic [dataWidth-1:0]   opData;
    logic [addrWidth-1:0]   opOffset;
    logic                   opReady;
    logic [addrWidth-1:0]   stackUpperBound;
    logic [addrWidth-1:0]   stackLowerBound;
    logic                   stackDirection;
    logic                   resultValid;
    logic [dataWidth-1:0]   resultData;
    resultFaultT            resultFault;
    logic                   resultReady;
    logic                   fillReq;
    logic [lineNumBits-1:0] fillLine;
    logic                   fillAck;
    logic [lineWidth-1:0]   fillData;
    logic                   evictReq;
    logic [lineNumBits-1:0] evictLine;
    logic [lineWidth-1:0]   evictData;
    logic                   evictAck;
    logic [addrWidth-1:0]   stackPointer;

    integer               seed = 79;
    int                   cycleCount = 0;
    int                   memWait;
    logic [dataWidth-1:0] backMem [windowWords];
    logic [dataWidth-1:0] modelMem [windowWords];
    logic [addrWidth-1:0] modelSp;
    // Operation waiting for opReady
    logic                 opPending;
    stackOpT              pendCode;
    logic [dataWidth-1:0] pendData;
    logic [addrWidth-1:0] pendOffset;
    // Expected results in issue order
    logic [dataWidth-1:0] expData [$];
    resultFaultT          expFault [$];
    logic [addrWidth-1:0] expSp [$];

    stackCache u_stackCache (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            abortRun($sformatf("timeout: the run did not finish within %0d cycles", cycleLimit));
        end
    end

    task automatic abortRun(input string what);
        $display("%s", what);
        $display("Some tests failed");
        $fatal(1);
    endtask

    // One step toward growth
    function automatic logic [addrWidth-1:0] stepToward(input logic [addrWidth-1:0] sp,
                                                        input logic dir);
        return dir ? sp + 32'd1 : sp - 32'd1;
    endfunction

    // k words deeper into the stack
    function automatic logic [addrWidth-1:0] awayFromTop(input logic [addrWidth-1:0] sp,
                                                         input logic [addrWidth-1:0] k,
                                                         input logic dir);
        return dir ? sp - k : sp + k;
    endfunction

    function automatic logic lineInWindow(input logic [lineNumBits-1:0] line);
        logic [addrWidth-1:0] base;
        base = {line, {wordOffsetBits{1'b0}}};
        return (base >= lowerBound) && (base + lineWords - 1 <= upperBound);
    endfunction

    function automatic logic [lineWidth-1:0] lineFromMemory(input logic [lineNumBits-1:0] line);
        logic [lineWidth-1:0] bits;
        logic [addrWidth-1:0] base;
        base = {line, {wordOffsetBits{1'b0}}};
        for (int w = 0; w < lineWords; w++) begin
            bits[w*dataWidth +: dataWidth] = backMem[base + w - lowerBound];
        end
        return bits;
    endfunction

    task automatic storeEvictedLine();
        logic [addrWidth-1:0] base;
        base = {evictLine, {wordOffsetBits{1'b0}}};
        for (int w = 0; w < lineWords; w++) begin
            backMem[base + w - lowerBound] = evictData[w*dataWidth +: dataWidth];
        end
    endtask

    // Reference stack, applied in transfer order
    task automatic applyModel(input stackOpT code, input logic [dataWidth-1:0] data,
                              input logic [addrWidth-1:0] off);
        logic [addrWidth-1:0] addr;
        logic [addrWidth-1:0] newSp;
        logic [dataWidth-1:0] rd;
        logic                 bad;
        rd = '0;
        case (code)
            opPush: begin
                addr  = stepToward(modelSp, stackDirection);
                newSp = addr;
            end
            opPop: begin
                addr  = modelSp;
                newSp = awayFromTop(modelSp, 32'd1, stackDirection);
            end
            opPick, opPlace: begin
                addr  = awayFromTop(modelSp, off, stackDirection);
                newSp = modelSp;
            end
            default: begin
                addr  = off;
                newSp = off;
            end
        endcase
        bad = (code != opSetSp) && ((addr < lowerBound) || (addr > upperBound));
        // A faulted op leaves memory and pointer alone
        if (!bad) begin
            if ((code == opPush) || (code == opPlace)) begin
                modelMem[addr - lowerBound] = data;
            end
            if ((code == opPop) || (code == opPick)) begin
                rd = modelMem[addr - lowerBound];
            end
            modelSp = newSp;
        end
        expData.push_back(rd);
        expFault.push_back(bad ? faultBounds : faultNone);
        expSp.push_back(modelSp);
    endtask

    task automatic checkResult();
        logic [dataWidth-1:0] eData;
        resultFaultT          eFault;
        logic [addrWidth-1:0] eSp;
        int                   outstanding;
        assert (expData.size() != 0)
            else abortRun("a result arrived with no operation outstanding");
        outstanding = expData.size();
        eData  = expData.pop_front();
        eFault = expFault.pop_front();
        eSp    = expSp.pop_front();
        assert (resultFault == eFault)
            else abortRun($sformatf("error at %0t: result fault expected %0d got %0d",
                                    $time, eFault, resultFault));
        assert (resultData == eData)
            else abortRun($sformatf("error at %0t: result data expected %h got %h",
                                    $time, eData, resultData));
        // Only op in flight, so the pointer is final
        if (outstanding == 1) begin
            assert (stackPointer == eSp)
                else abortRun($sformatf("error at %0t: stack pointer expected %h got %h",
                                        $time, eSp, stackPointer));
        end
    endtask

    // One clock of stimulus, memory responder and checks
    task automatic cycleStep();
        @(negedge clk);
        resultReady = ($unsigned($random(seed)) % 4) != 0;
        fillAck  = 1'b0;
        evictAck = 1'b0;
        // Backing memory answers 1 to 4 cycles after a request appears
        if ((fillReq || evictReq) && (memWait == 0)) begin
            memWait = 2 + $unsigned($random(seed)) % 4;
        end
        if (memWait != 0) begin
            memWait = memWait - 1;
            if ((memWait == 0) && fillReq) begin
                assert (lineInWindow(fillLine))
                    else abortRun("a fill asked for a line outside the backing memory");
                fillAck  = 1'b1;
                fillData = lineFromMemory(fillLine);
            end else if (memWait == 0) begin
                assert (lineInWindow(evictLine))
                    else abortRun("an evict wrote a line outside the backing memory");
                evictAck = 1'b1;
                storeEvictedLine();
            end
        end
        opValid  = opPending;
        opCode   = pendCode;
        opData   = pendData;
        opOffset = pendOffset;
        // Let combinational outputs settle before sampling
        #1;
        assert (!(fillReq && evictReq))
            else abortRun($sformatf("error at %0t: fill and evict requested together", $time));
        if (resultValid && resultReady) begin
            checkResult();
        end
        if (opValid && opReady) begin
            applyModel(pendCode, pendData, pendOffset);
            opPending = 1'b0;
        end
    endtask

    task automatic issueOp(input stackOpT code, input logic [dataWidth-1:0] data,
                           input logic [addrWidth-1:0] off);
        int gap;
        // Idle gaps now and then
        gap = (($unsigned($random(seed)) % 4) == 0) ? 1 + $unsigned($random(seed)) % 3 : 0;
        repeat (gap) cycleStep();
        pendCode   = code;
        pendData   = data;
        pendOffset = off;
        opPending  = 1'b1;
        while (opPending) cycleStep();
    endtask

    task automatic randomOp();
        int                   r;
        stackOpT              code;
        logic [addrWidth-1:0] off;
        r   = $unsigned($random(seed)) % 16;
        off = $unsigned($random(seed)) % 40;
        // Pushes dominate so the stack drifts deeper
        if (r < 7) begin
            code = opPush;
        end else if (r < 11) begin
            code = opPop;
        end else if (r < 13) begin
            code = opPick;
        end else if (r < 15) begin
            code = opPlace;
        end else begin
            code = opSetSp;
            off  = lowerBound + $unsigned($random(seed)) % windowWords;
        end
        issueOp(code, 16'($random(seed)), off);
    endtask

    task automatic runPhase(input logic dir);
        @(negedge clk);
        stackDirection = dir;
        rstN      = 1'b0;
        opValid   = 1'b0;
        fillAck   = 1'b0;
        evictAck  = 1'b0;
        memWait   = 0;
        opPending = 1'b0;
        repeat (10) @(negedge clk);
        rstN    = 1'b1;
        modelSp = dir ? lowerBound - 32'd1 : upperBound + 32'd1;
        #1;
        assert (stackPointer == modelSp)
            else abortRun($sformatf("error at %0t: reset pointer expected %h got %h",
                                    $time, modelSp, stackPointer));
        // Pop of an empty stack runs past the bound
        issueOp(opPop, '0, '0);
        repeat (opsPerPhase / 2) randomOp();
        // Full stack, then a push and a deep pick both fault
        issueOp(opSetSp, '0, dir ? upperBound : lowerBound);
        issueOp(opPush, 16'hBEEF, '0);
        issueOp(opPick, '0, 32'd200);
        repeat (opsPerPhase / 2) randomOp();
        // Closing SetSp writes every dirty line back
        issueOp(opSetSp, '0, dir ? lowerBound - 32'd1 : upperBound + 32'd1);
        while (expData.size() != 0) cycleStep();
        for (int i = 0; i < windowWords; i++) begin
            assert (backMem[i] == modelMem[i])
                else abortRun($sformatf("error at %0t: memory word %h expected %h got %h",
                                        $time, lowerBound + i, modelMem[i], backMem[i]));
        end
    endtask

    initial begin
        rstN            = 1'b0;
        opValid         = 1'b0;
        opCode          = opPush;
        opData          = '0;
        opOffset        = '0;
        stackUpperBound = upperBound;
        stackLowerBound = lowerBound;
        stackDirection  = 1'b0;
        resultReady     = 1'b0;
        fillAck         = 1'b0;
        fillData        = '0;
        evictAck        = 1'b0;
        memWait         = 0;
        opPending       = 1'b0;
        pendCode        = opPush;
        pendData        = '0;
        pendOffset      = '0;
        // Word pattern from the full address
        for (int i = 0; i < windowWords; i++) begin
            backMem[i]  = 16'(((lowerBound + i) * 32'h9E37) ^ 32'h5A5A);
            modelMem[i] = backMem[i];
        end
        // Grow down first, then grow up after a fresh reset
        runPhase(1'b0);
        runPhase(1'b1);
        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== stackCache.f ====
stackCfgPkg.sv
stackOpPkg.sv
stackOpDecode.sv
stackLineStore.sv
stackExecute.sv
stackResult.sv
stackCache.sv
tbStackCache.sv
